// ==== hw/rv_pkg.sv ====
`default_nettype none

package rv_pkg;

  // datapath and register index widths
  localparam int xlen       = 32;
  localparam int reg_addr_w = 5;

  localparam logic [xlen-1:0] reset_pc = 32'h8000_0000;

  // major opcodes, inst[6:0]
  localparam logic [6:0] op_lui    = 7'b011_0111;
  localparam logic [6:0] op_auipc  = 7'b001_0111;
  localparam logic [6:0] op_jal    = 7'b110_1111;
  localparam logic [6:0] op_jalr   = 7'b110_0111;
  localparam logic [6:0] op_branch = 7'b110_0011;
  localparam logic [6:0] op_load   = 7'b000_0011;
  localparam logic [6:0] op_store  = 7'b010_0011;
  localparam logic [6:0] op_imm    = 7'b001_0011;
  localparam logic [6:0] op_reg    = 7'b011_0011;

  // funct3 for register and immediate arithmetic
  localparam logic [2:0] f3_add  = 3'b000;
  localparam logic [2:0] f3_sll  = 3'b001;
  localparam logic [2:0] f3_slt  = 3'b010;
  localparam logic [2:0] f3_sltu = 3'b011;
  localparam logic [2:0] f3_xor  = 3'b100;
  localparam logic [2:0] f3_sr   = 3'b101; // srl / sra
  localparam logic [2:0] f3_or   = 3'b110;
  localparam logic [2:0] f3_and  = 3'b111;

  // funct3 for conditional branches
  localparam logic [2:0] f3_beq  = 3'b000;
  localparam logic [2:0] f3_bne  = 3'b001;
  localparam logic [2:0] f3_blt  = 3'b100;
  localparam logic [2:0] f3_bge  = 3'b101;
  localparam logic [2:0] f3_bltu = 3'b110;
  localparam logic [2:0] f3_bgeu = 3'b111;

  localparam logic [6:0] f7_alt = 7'b010_0000; // sub, sra

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and
  } alu_op_t;

  // source of the rd write
  typedef enum logic [2:0] {
    wb_alu,
    wb_mem,
    wb_pc4,
    wb_imm,
    wb_target
  } wb_sel_t;

  typedef enum logic [2:0] {
    imm_i,
    imm_s,
    imm_b,
    imm_u,
    imm_j
  } imm_sel_t;

endpackage

`default_nettype wire

// ==== hw/reg_file.sv ====
`default_nettype none

module reg_file (
  input  logic                         clk,
  input  logic [rv_pkg::reg_addr_w-1:0] rs1_addr,
  input  logic [rv_pkg::reg_addr_w-1:0] rs2_addr,
  output logic [rv_pkg::xlen-1:0]       rs1_data,
  output logic [rv_pkg::xlen-1:0]       rs2_data,
  input  logic [rv_pkg::reg_addr_w-1:0] rd_addr,
  input  logic                         rd_we,
  input  logic [rv_pkg::xlen-1:0]       rd_data
);
  import rv_pkg::*;

  // x1..x31 only, x0 has no storage
  logic [xlen-1:0] regs [1:31];

  logic rs1_zero;
  logic rs2_zero;

  assign rs1_zero = (rs1_addr == '0);
  assign rs2_zero = (rs2_addr == '0);

  // asynchronous read ports
  always_comb begin
    rs1_data = '0;
    if (!rs1_zero) begin
      rs1_data = regs[rs1_addr];
    end
  end

  always_comb begin
    rs2_data = '0;
    if (!rs2_zero) begin
      rs2_data = regs[rs2_addr];
    end
  end

  // write lands at the retiring edge
  always_ff @(posedge clk) begin
    if (rd_we && (rd_addr != '0)) begin
      regs[rd_addr] <= rd_data;
    end
  end

endmodule

`default_nettype wire

// ==== hw/imm_gen.sv ====
`default_nettype none

module imm_gen (
  input  logic [rv_pkg::xlen-1:0] inst,
  input  rv_pkg::imm_sel_t        imm_sel,
  output logic [rv_pkg::xlen-1:0] imm
);
  import rv_pkg::*;

  logic            sign;
  logic [xlen-1:0] i_imm;
  logic [xlen-1:0] s_imm;
  logic [xlen-1:0] b_imm;
  logic [xlen-1:0] u_imm;
  logic [xlen-1:0] j_imm;

  assign sign = inst[31];

  // shift-immediates keep the full I field, alu only looks at [4:0]
  assign i_imm = {{20{sign}}, inst[31:20]};
  assign s_imm = {{20{sign}}, inst[31:25], inst[11:7]};

  // branch offset, bit 0 implied zero
  assign b_imm = {{19{sign}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};

  assign u_imm = {inst[31:12], 12'h000};

  // jal offset
  assign j_imm = {{11{sign}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

  always_comb begin
    case (imm_sel)
      imm_i:   imm = i_imm;
      imm_s:   imm = s_imm;
      imm_b:   imm = b_imm;
      imm_u:   imm = u_imm;
      imm_j:   imm = j_imm;
      default: imm = i_imm;
    endcase
  end

endmodule

`default_nettype wire

// ==== hw/decoder.sv ====
`default_nettype none

module decoder (
  input  logic                    rst_n,
  input  logic [rv_pkg::xlen-1:0] inst,
  output rv_pkg::alu_op_t         alu_op,
  output rv_pkg::imm_sel_t        imm_sel,
  output logic                    src_b_imm,
  output logic                    reg_we,
  output rv_pkg::wb_sel_t         wb_sel,
  output logic                    dmem_we,
  output logic                    is_branch,
  output logic                    is_jal,
  output logic                    is_jalr,
  output logic [2:0]              branch_cond
);
  import rv_pkg::*;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       alt;
  logic       reg_we_d;
  logic       dmem_we_d;

  // arithmetic op from funct3, alt picks sub / sra
  function automatic alu_op_t arith_op(input logic [2:0] f3, input logic alt_op);
    case (f3)
      f3_add:  arith_op = alt_op ? alu_sub : alu_add;
      f3_sll:  arith_op = alu_sll;
      f3_slt:  arith_op = alu_slt;
      f3_sltu: arith_op = alu_sltu;
      f3_xor:  arith_op = alu_xor;
      f3_sr:   arith_op = alt_op ? alu_sra : alu_srl;
      f3_or:   arith_op = alu_or;
      default: arith_op = alu_and;
    endcase
  endfunction

  assign opcode      = inst[6:0];
  assign funct3      = inst[14:12];
  assign funct7      = inst[31:25];
  assign alt         = (funct7 == f7_alt);
  assign branch_cond = funct3;

  always_comb begin
    // defaults give a no-op for unknown opcodes
    alu_op    = alu_add;
    imm_sel   = imm_i;
    src_b_imm = 1'b0;
    reg_we_d  = 1'b0;
    wb_sel    = wb_alu;
    dmem_we_d = 1'b0;
    is_branch = 1'b0;
    is_jal    = 1'b0;
    is_jalr   = 1'b0;
    case (opcode)
      op_reg: begin
        alu_op   = arith_op(funct3, alt);
        reg_we_d = 1'b1;
      end
      op_imm: begin
        // no subi, alt only matters for srai
        alu_op    = arith_op(funct3, alt && (funct3 == f3_sr));
        src_b_imm = 1'b1;
        reg_we_d  = 1'b1;
      end
      op_load: begin
        src_b_imm = 1'b1; // base + offset
        reg_we_d  = 1'b1;
        wb_sel    = wb_mem;
      end
      op_store: begin
        imm_sel   = imm_s;
        src_b_imm = 1'b1;
        dmem_we_d = 1'b1;
      end
      op_branch: begin
        imm_sel   = imm_b;
        alu_op    = alu_sub;
        is_branch = 1'b1;
      end
      op_jal: begin
        imm_sel  = imm_j;
        reg_we_d = 1'b1;
        wb_sel   = wb_pc4;
        is_jal   = 1'b1;
      end
      op_jalr: begin
        src_b_imm = 1'b1;
        reg_we_d  = 1'b1;
        wb_sel    = wb_pc4;
        is_jalr   = 1'b1;
      end
      op_lui: begin
        imm_sel  = imm_u;
        reg_we_d = 1'b1;
        wb_sel   = wb_imm;
      end
      op_auipc: begin
        imm_sel  = imm_u;
        reg_we_d = 1'b1;
        wb_sel   = wb_target; // pc + imm from pc_unit
      end
      default: ;
    endcase
  end

  // no architectural writes while in reset
  assign reg_we  = rst_n & reg_we_d;
  assign dmem_we = rst_n & dmem_we_d;

endmodule

`default_nettype wire

// ==== hw/alu.sv ====
`default_nettype none

module alu (
  input  logic [rv_pkg::xlen-1:0] a,
  input  logic [rv_pkg::xlen-1:0] b,
  input  rv_pkg::alu_op_t         alu_op,
  input  logic [2:0]              branch_cond,
  output logic [rv_pkg::xlen-1:0] result,
  output logic                    taken
);
  import rv_pkg::*;

  logic [xlen:0]   diff; // extra bit is the borrow
  logic [xlen-1:0] sum;
  logic [4:0]      shamt;
  logic            eq;
  logic            lt;
  logic            ltu;

  assign sum   = a + b;
  assign diff  = {1'b0, a} - {1'b0, b};
  assign shamt = b[4:0];

  // comparator flags, shared by slt/sltu and branches
  assign eq  = (diff[xlen-1:0] == '0);
  assign ltu = diff[xlen];
  // sign bits differ: the negative one is smaller
  assign lt  = (a[xlen-1] != b[xlen-1]) ? a[xlen-1] : diff[xlen-1];

  always_comb begin
    case (alu_op)
      alu_add:  result = sum;
      alu_sub:  result = diff[xlen-1:0];
      alu_sll:  result = a << shamt;
      alu_slt:  result = {{(xlen-1){1'b0}}, lt};
      alu_sltu: result = {{(xlen-1){1'b0}}, ltu};
      alu_xor:  result = a ^ b;
      alu_srl:  result = a >> shamt;
      alu_sra:  result = $signed(a) >>> shamt;
      alu_or:   result = a | b;
      alu_and:  result = a & b;
      default:  result = sum;
    endcase
  end

  // branch condition, only used when the decoder flags a branch
  always_comb begin
    case (branch_cond)
      f3_beq:  taken = eq;
      f3_bne:  taken = !eq;
      f3_blt:  taken = lt;
      f3_bge:  taken = !lt;
      f3_bltu: taken = ltu;
      f3_bgeu: taken = !ltu;
      default: taken = 1'b0; // 010 / 011 are not branches
    endcase
  end

endmodule

`default_nettype wire

// ==== hw/pc_unit.sv ====
`default_nettype none

module pc_unit (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic [rv_pkg::xlen-1:0] imm,
  input  logic [rv_pkg::xlen-1:0] rs1_data,
  input  logic                    is_branch,
  input  logic                    taken,
  input  logic                    is_jal,
  input  logic                    is_jalr,
  output logic [rv_pkg::xlen-1:0] pc,
  output logic [rv_pkg::xlen-1:0] pc_plus4,
  output logic [rv_pkg::xlen-1:0] target,
  output logic [rv_pkg::xlen-1:0] next_pc
);
  import rv_pkg::*;

  logic [xlen-1:0] base;
  logic [xlen-1:0] sum;
  logic            redirect;

  assign pc_plus4 = pc + 32'd4;

  // jalr adds to rs1, everything else is pc relative
  assign base = is_jalr ? rs1_data : pc;
  assign sum  = base + imm;

  assign target = is_jalr ? {sum[xlen-1:1], 1'b0} : sum;

  assign redirect = is_jal | is_jalr | (is_branch & taken);
  assign next_pc  = redirect ? target : pc_plus4;

  // one instruction retires per edge
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc <= reset_pc;
    end else begin
      pc <= next_pc;
    end
  end

endmodule

`default_nettype wire

// ==== hw/rv_core.sv ====
`default_nettype none

module rv_core (
  input  logic                    clk,
  input  logic                    rst_n,
  output logic [rv_pkg::xlen-1:0] imem_addr,
  input  logic [rv_pkg::xlen-1:0] inst,
  output logic [rv_pkg::xlen-1:0] dmem_addr,
  output logic                    dmem_we,
  output logic [rv_pkg::xlen-1:0] dmem_wdata,
  input  logic [rv_pkg::xlen-1:0] dmem_rdata
);
  import rv_pkg::*;

  alu_op_t         alu_op;
  imm_sel_t        imm_sel;
  wb_sel_t         wb_sel;
  logic            src_b_imm;
  logic            reg_we;
  logic            is_branch;
  logic            is_jal;
  logic            is_jalr;
  logic            taken;
  logic [2:0]      branch_cond;
  logic [xlen-1:0] imm;
  logic [xlen-1:0] rs1_data;
  logic [xlen-1:0] rs2_data;
  logic [xlen-1:0] alu_b;
  logic [xlen-1:0] alu_result;
  logic [xlen-1:0] rd_data;
  logic [xlen-1:0] pc;
  logic [xlen-1:0] pc_plus4;
  logic [xlen-1:0] target;

  decoder i_decoder (
    .rst_n       (rst_n),
    .inst        (inst),
    .alu_op      (alu_op),
    .imm_sel     (imm_sel),
    .src_b_imm   (src_b_imm),
    .reg_we      (reg_we),
    .wb_sel      (wb_sel),
    .dmem_we     (dmem_we),
    .is_branch   (is_branch),
    .is_jal      (is_jal),
    .is_jalr     (is_jalr),
    .branch_cond (branch_cond)
  );

  imm_gen i_imm_gen (
    .inst    (inst),
    .imm_sel (imm_sel),
    .imm     (imm)
  );

  reg_file i_reg_file (
    .clk      (clk),
    .rs1_addr (inst[19:15]),
    .rs2_addr (inst[24:20]),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .rd_addr  (inst[11:7]),
    .rd_we    (reg_we),
    .rd_data  (rd_data)
  );

  assign alu_b = src_b_imm ? imm : rs2_data;

  alu i_alu (
    .a           (rs1_data),
    .b           (alu_b),
    .alu_op      (alu_op),
    .branch_cond (branch_cond),
    .result      (alu_result),
    .taken       (taken)
  );

  pc_unit i_pc_unit (
    .clk       (clk),
    .rst_n     (rst_n),
    .imm       (imm),
    .rs1_data  (rs1_data),
    .is_branch (is_branch),
    .taken     (taken),
    .is_jal    (is_jal),
    .is_jalr   (is_jalr),
    .pc        (pc),
    .pc_plus4  (pc_plus4),
    .target    (target),
    .next_pc   ()
  );

  assign imem_addr = pc;

  // word accesses only, low two bits dropped
  assign dmem_addr  = {alu_result[xlen-1:2], 2'b00};
  assign dmem_wdata = rs2_data;

  // rd writeback source
  always_comb begin
    case (wb_sel)
      wb_alu:    rd_data = alu_result;
      wb_mem:    rd_data = dmem_rdata;
      wb_pc4:    rd_data = pc_plus4; // jal / jalr link
      wb_imm:    rd_data = imm;      // lui
      wb_target: rd_data = target;   // auipc
      default:   rd_data = alu_result;
    endcase
  end

endmodule

`default_nettype wire

// ==== tests/tb_clock.sv ====
`default_nettype none

module tb_clock (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk; // period 8
  end

  // reset held over two rising edges, released just after the second
  initial begin
    rst_n = 1'b0;
    repeat (2) @(posedge clk);
    #1 rst_n = 1'b1;
  end

endmodule

`default_nettype wire

// ==== tests/tb_rv_core.sv ====
`default_nettype none

module tb_rv_core;
  import rv_pkg::*;

  localparam int n_pre      = 63;  // sw at reset pc, then lui/addi pairs for x1..x31
  localparam int n_rand     = 400;
  localparam int n_dump     = 32;  // x0..x31 stored through x1
  localparam int prog_len   = n_pre + n_rand + n_dump;
  localparam int dump_start = n_pre + n_rand;
  localparam int max_cycles = 4 * prog_len + 100;
  localparam logic [31:0] nop    = 32'h0000_0013;
  localparam logic [31:0] end_pc = reset_pc + 32'(4 * prog_len);

  logic        clk;
  logic        rst_n;
  logic [31:0] imem_addr;
  logic [31:0] inst;
  logic [31:0] dmem_addr;
  logic        dmem_we;
  logic [31:0] dmem_wdata;
  logic [31:0] dmem_rdata;

  logic [31:0] imem [0:1023];
  logic [31:0] dmem [0:1023];
  logic [31:0] model_mem [0:1023];
  logic [31:0] model_regs [0:31];
  logic [31:0] model_pc;
  logic        exp_we;
  logic [31:0] exp_addr;
  logic [31:0] exp_data;
  integer      seed;
  int          n_checks;
  int          n_errors;
  int          cycles;

  tb_clock i_clock (
    .clk   (clk),
    .rst_n (rst_n)
  );

  rv_core i_dut (
    .clk        (clk),
    .rst_n      (rst_n),
    .imem_addr  (imem_addr),
    .inst       (inst),
    .dmem_addr  (dmem_addr),
    .dmem_we    (dmem_we),
    .dmem_wdata (dmem_wdata),
    .dmem_rdata (dmem_rdata)
  );

  function automatic logic [31:0] rand_below(input int unsigned n);
    return $unsigned($random(seed)) % n;
  endfunction

  // rd never hits the base registers x1..x4
  function automatic logic [4:0] rand_rd();
    logic [31:0] r;
    r = rand_below(28);
    return (r == 0) ? 5'd0 : 5'(r + 4);
  endfunction

  function automatic logic [31:0] fill_word(input int idx);
    return (32'(idx) * 32'h9e37_79b1) ^ 32'h5a5a_0000;
  endfunction

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, op_reg};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], op_store};
  endfunction

  function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], op_branch};
  endfunction

  function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                        input logic [6:0] op);
    return {imm, rd, op};
  endfunction

  function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, op_jal};
  endfunction

  // reference arithmetic per the ISA
  function automatic logic [31:0] arith(input logic [2:0] f3, input logic alt,
                                        input logic [31:0] a, input logic [31:0] b);
    logic [31:0] r;
    case (f3)
      3'd0: r = alt ? a - b : a + b;
      3'd1: r = a << b[4:0];
      3'd2: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'd3: r = (a < b) ? 32'd1 : 32'd0;
      3'd4: r = a ^ b;
      3'd5: begin
        if (alt) r = $signed(a) >>> b[4:0];
        else r = a >> b[4:0];
      end
      3'd6: r = a | b;
      default: r = a & b;
    endcase
    return r;
  endfunction

  task automatic build_program();
    int           k;
    int           tgt;
    logic [31:0]  r;
    logic [2:0]   f3;
    logic [11:0]  imm;
    logic [1023:0] hit; // slots some earlier jump lands on
    hit = '0;
    for (int i = 0; i < 1024; i++) begin
      imem[i]      = nop;
      dmem[i]      = fill_word(i);
      model_mem[i] = fill_word(i);
    end
    // store at the reset pc, must stay off while in reset
    imem[0] = enc_s(12'd0, 5'd0, 5'd0);
    for (int n = 1; n < 32; n++) begin
      r = $random(seed);
      if (n <= 4) begin
        // base pointers 0x10000, 0x10100, 0x10200, 0x10300
        imem[2*n-1] = enc_u(20'h00010, 5'(n), op_lui);
        imem[2*n]   = enc_i(12'((n - 1) * 256), 5'(n), 3'b000, 5'(n), op_imm);
      end else begin
        imem[2*n-1] = enc_u(r[31:12], 5'(n), op_lui);
        imem[2*n]   = enc_i(r[11:0], 5'(n), 3'b000, 5'(n), op_imm);
      end
    end
    k = n_pre;
    while (k < dump_start) begin
      r   = $random(seed);
      f3  = 3'(rand_below(8));
      imm = r[11:0];
      tgt = k + 2 + int'(rand_below(7)); // forward only, so the run ends
      if (tgt > dump_start) tgt = dump_start;
      case (rand_below(10))
        0, 1: begin
          imem[k] = enc_r(((f3 == 3'd0 || f3 == 3'd5) && r[20]) ? f7_alt : 7'd0,
                          5'(rand_below(32)), 5'(rand_below(32)), f3, rand_rd());
        end
        2, 3: begin
          if (f3 == 3'd1) imm = {7'd0, r[4:0]};
          if (f3 == 3'd5) imm = {r[20] ? f7_alt : 7'd0, r[4:0]};
          imem[k] = enc_i(imm, 5'(rand_below(32)), f3, rand_rd(), op_imm);
        end
        4: imem[k] = enc_u(r[31:12], rand_rd(), r[0] ? op_lui : op_auipc);
        5: imem[k] = enc_i(12'(4 * rand_below(64)), 5'(1 + rand_below(4)), 3'b010,
                           rand_rd(), op_load);
        6: imem[k] = enc_s(12'(4 * rand_below(64)), 5'(rand_below(32)),
                           5'(1 + rand_below(4)));
        7: begin
          f3 = 3'(rand_below(6));
          if (f3 >= 3'd2) f3 = f3 + 3'd2; // skip 010 / 011
          imem[k] = enc_b(13'(4 * (tgt - k)), 5'(rand_below(32)), 5'(rand_below(32)), f3);
          hit[tgt] = 1'b1;
        end
        8: begin
          imem[k]  = enc_j(21'(4 * (tgt - k)), rand_rd());
          hit[tgt] = 1'b1;
        end
        default: begin
          // jalr needs its auipc, so no jump may land between the two
          if (k + 1 < dump_start && !hit[k+1]) begin
            // auipc into a scratch reg, then jalr off it, odd offset sometimes
            imem[k]   = enc_u(20'd0, 5'(5 + rand_below(27)), op_auipc);
            imem[k+1] = enc_i(12'(4 * (tgt - k) + int'(r[1])), imem[k][11:7], 3'b000,
                              rand_rd(), op_jalr);
            hit[tgt]  = 1'b1;
            k++;
          end
        end
      endcase
      k++;
    end
    for (int n = 0; n < n_dump; n++) begin
      imem[dump_start + n] = enc_s(12'(4 * n), 5'(n), 5'd1);
    end
  endtask

  // retire one instruction in the model, giving the expected store
  task automatic model_step();
    logic [31:0] ins;
    logic [31:0] rs1v;
    logic [31:0] rs2v;
    logic [31:0] ii;
    logic [31:0] ui;
    logic [31:0] val;
    logic [31:0] addr;
    logic [31:0] nxt;
    logic        wr;
    logic        cond;
    ins  = imem[model_pc[11:2]];
    rs1v = model_regs[ins[19:15]];
    rs2v = model_regs[ins[24:20]];
    ii   = {{20{ins[31]}}, ins[31:20]};
    ui   = {ins[31:12], 12'h000};
    nxt  = model_pc + 32'd4;
    wr   = 1'b1;
    val  = '0;
    exp_we   = 1'b0;
    exp_addr = '0;
    exp_data = '0;
    case (ins[6:0])
      op_lui:   val = ui;
      op_auipc: val = model_pc + ui;
      op_jal: begin
        val = model_pc + 32'd4;
        nxt = model_pc + {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
      end
      op_jalr: begin
        val = model_pc + 32'd4;
        nxt = (rs1v + ii) & ~32'd1;
      end
      op_branch: begin
        wr = 1'b0;
        case (ins[14:12])
          3'd0: cond = (rs1v == rs2v);
          3'd1: cond = (rs1v != rs2v);
          3'd4: cond = ($signed(rs1v) < $signed(rs2v));
          3'd5: cond = ($signed(rs1v) >= $signed(rs2v));
          3'd6: cond = (rs1v < rs2v);
          3'd7: cond = (rs1v >= rs2v);
          default: cond = 1'b0;
        endcase
        if (cond) begin
          nxt = model_pc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
        end
      end
      op_load: begin
        addr = rs1v + ii;
        val  = model_mem[addr[11:2]];
      end
      op_store: begin
        wr       = 1'b0;
        addr     = rs1v + {{20{ins[31]}}, ins[31:25], ins[11:7]};
        exp_we   = 1'b1;
        exp_addr = {addr[31:2], 2'b00};
        exp_data = rs2v;
        model_mem[addr[11:2]] = rs2v;
      end
      op_imm: val = arith(ins[14:12], ins[30] && (ins[14:12] == 3'd5), rs1v, ii);
      op_reg: val = arith(ins[14:12], ins[30], rs1v, rs2v);
      default: wr = 1'b0;
    endcase
    if (wr && ins[11:7] != 5'd0) model_regs[ins[11:7]] = val;
    model_pc = nxt;
  endtask

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    n_checks++;
    assert (got === exp) else begin
      n_errors++;
      $display("CHECK FAILED time %0t %s: got %h, expected %h", $time, name, got, exp);
    end
  endtask

  // fetch and read data a fixed delay after each edge
  always @(posedge clk) begin
    #1 inst = imem[imem_addr[11:2]];
    #1 dmem_rdata = dmem[dmem_addr[11:2]];
  end

  initial begin
    logic        done;
    logic        st_we;
    logic [31:0] st_addr;
    logic [31:0] st_data;
    seed       = 32'he1bdef30;
    inst       = nop;
    dmem_rdata = '0;
    n_checks   = 0;
    n_errors   = 0;
    cycles     = 0;
    done       = 1'b0;
    build_program();
    model_pc = reset_pc;
    for (int i = 0; i < 32; i++) model_regs[i] = '0;
    @(negedge clk);
    while (!rst_n) begin
      check_eq("imem_addr", imem_addr, reset_pc);
      check_eq("dmem_we", {31'd0, dmem_we}, 32'd0);
      @(negedge clk);
    end
    while (!done) begin
      check_eq("imem_addr", imem_addr, model_pc);
      if (model_pc == end_pc) begin
        done = 1'b1;
      end else if (cycles >= max_cycles) begin
        n_errors++;
        $display("timeout: program end not reached after %0d cycles", cycles);
        done = 1'b1;
      end else begin
        model_step();
        check_eq("dmem_we", {31'd0, dmem_we}, {31'd0, exp_we});
        if (exp_we) begin
          check_eq("dmem_addr", dmem_addr, exp_addr);
          check_eq("dmem_wdata", dmem_wdata, exp_data);
        end
        st_we   = dmem_we;
        st_addr = dmem_addr;
        st_data = dmem_wdata;
        @(posedge clk);
        if (st_we) dmem[st_addr[11:2]] = st_data; // store lands at the edge
        cycles++;
        @(negedge clk);
      end
    end
    $display("checks %0d, errors %0d, cycles %0d", n_checks, n_errors, cycles);
    if (n_errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim.f ====
hw/rv_pkg.sv
hw/reg_file.sv
hw/imm_gen.sv
hw/decoder.sv
hw/alu.sv
hw/pc_unit.sv
hw/rv_core.sv
tests/tb_clock.sv
tests/tb_rv_core.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --binary --assert -Wno-fatal
LINTFLAGS ?= --lint-only -Wall
TOP       := tb_rv_core
DUT_TOP   := rv_core
FILELIST  := sim.f
OBJDIR    := obj_dir
LOG       := sim.log

.PHONY: all run lint clean

all: run

run:
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "STATUS: PASS" $(LOG); then echo "no pass status in $(LOG)"; exit 1; fi

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)
	$(VERILATOR) $(LINTFLAGS) hw/rv_pkg.sv hw/reg_file.sv hw/imm_gen.sv hw/decoder.sv \
		hw/alu.sv hw/pc_unit.sv hw/rv_core.sv --top-module $(DUT_TOP)

clean:
	rm -rf $(OBJDIR) $(LOG)
